// ==== data_memory.sv ====
module data_memory #(
    parameter int addr_width = 12
) (
    input  logic       clk,
    input  logic       rst_n,
    mem_bus_if.memory  bus
);
    import mem_wb_pkg::*;

    localparam int depth = 2 ** addr_width;

    logic [7:0]            mem [depth];
    logic [addr_width-1:0] a0;
    logic [addr_width-1:0] a1;
    logic [addr_width-1:0] a2;
    logic [addr_width-1:0] a3;
    logic [7:0]            b0;
    logic [7:0]            b1;
    logic [7:0]            b2;
    logic [7:0]            b3;

    // consecutive byte lanes, wrapping at the top of memory
    assign a0 = bus.addr;
    assign a1 = bus.addr + addr_width'(1);
    assign a2 = bus.addr + addr_width'(2);
    assign a3 = bus.addr + addr_width'(3);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < depth; i++)
                mem[i] <= 8'h00;
        end
        else if (bus.we)
        begin
            case (bus.mode)
                mode_word:
                begin
                    mem[a0] <= bus.wdata[31:24]; // msb at lowest address
                    mem[a1] <= bus.wdata[23:16];
                    mem[a2] <= bus.wdata[15:8];
                    mem[a3] <= bus.wdata[7:0];
                end
                mode_half, mode_uhalf:
                begin
                    mem[a0] <= bus.wdata[15:8];
                    mem[a1] <= bus.wdata[7:0];
                end
                mode_byte, mode_ubyte:
                begin
                    mem[a0] <= bus.wdata[7:0];
                end
                default:
                begin
                    // no lanes written
                end
            endcase
        end
    end

    assign b0 = mem[a0];
    assign b1 = mem[a1];
    assign b2 = mem[a2];
    assign b3 = mem[a3];

    always_comb
    begin
        case (bus.mode)
            mode_half:  bus.rdata = {{(xlen - 16){b0[7]}}, b0, b1}; // sign extend
            mode_uhalf: bus.rdata = {{(xlen - 16){1'b0}}, b0, b1};
            mode_byte:  bus.rdata = {{(xlen - 8){b0[7]}}, b0};
            mode_ubyte: bus.rdata = {{(xlen - 8){1'b0}}, b0};
            default:    bus.rdata = {b0, b1, b2, b3};
        endcase
    end

endmodule

// ==== lsu_decode.sv ====
module lsu_decode #(
    parameter int addr_width = 12
) (
    input  logic [2:0]                  funct3,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic                        in_valid,
    input  logic [mem_wb_pkg::xlen-1:0] alu_result,
    input  logic [mem_wb_pkg::xlen-1:0] store_data,
    output logic                        misaligned,
    output logic [mem_wb_pkg::xlen-1:0] load_data,
    mem_bus_if.requester                bus
);
    import mem_wb_pkg::*;

    mem_mode_t             mode;
    logic                  mode_ok;
    logic                  aligned;
    logic [addr_width-1:0] addr;

    assign addr = alu_result[addr_width-1:0]; // modulo memory size

    always_comb
    begin
        mode    = mode_word;
        mode_ok = 1'b1;
        case (funct3)
            f3_word:  mode = mode_word;
            f3_half:  mode = mode_half;
            f3_byte:  mode = mode_byte;
            f3_uhalf: mode = mode_uhalf;
            f3_ubyte: mode = mode_ubyte;
            default:  mode_ok = 1'b0; // unknown width, treated as a trap
        endcase
    end

    always_comb
    begin
        case (mode)
            mode_word:              aligned = (addr[1:0] == 2'b00);
            mode_half, mode_uhalf:  aligned = ~addr[0];
            default:                aligned = 1'b1;
        endcase
    end

    assign misaligned = in_valid & (mem_read | mem_write) & ~(mode_ok & aligned);

    assign bus.addr  = addr;
    assign bus.wdata = store_data;
    assign bus.mode  = mode;
    assign bus.we    = in_valid & mem_write & ~misaligned; // bad stores never reach memory

    assign load_data = bus.rdata;

endmodule

// ==== mem_bus_if.sv ====
interface mem_bus_if #(
    parameter int addr_width = 12
);
    import mem_wb_pkg::*;

    logic [addr_width-1:0] addr;
    logic [xlen-1:0]       wdata;
    logic                  we;    // write at this edge
    mem_mode_t             mode;
    logic [xlen-1:0]       rdata; // combinational, same cycle

    modport requester (
        output addr,
        output wdata,
        output we,
        output mode,
        input  rdata
    );

    modport memory (
        input  addr,
        input  wdata,
        input  we,
        input  mode,
        output rdata
    );

endinterface

// ==== mem_wb_checker.sv ====
module mem_wb_checker (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic wb_valid,
    input logic wb_reg_write,
    input logic wb_trap,
    input logic misaligned,
    input logic bus_we
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0; // read by the testbench

    // synchronous reset clears the writeback controls at the next edge
    reset_clears: assert property (@(posedge clk)
        !rst_n |=> (!wb_valid && !wb_reg_write && !wb_trap))
        else begin $error("writeback controls not cleared by reset"); assert_fails++; end

    one_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> (wb_valid == $past(in_valid)))
        else begin $error("wb_valid does not follow in_valid by one cycle"); assert_fails++; end

    trap_blocks_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_trap && wb_reg_write))
        else begin $error("wb_reg_write high together with wb_trap"); assert_fails++; end

    no_misaligned_store: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_we && misaligned))
        else begin $error("memory write enabled on a misaligned access"); assert_fails++; end

endmodule

bind mem_wb_top mem_wb_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .wb_valid     (wb_valid),
    .wb_reg_write (wb_reg_write),
    .wb_trap      (wb_trap),
    .misaligned   (misaligned),
    .bus_we       (mem_bus.we)
);

// ==== mem_wb_pkg.sv ====
package mem_wb_pkg;

    localparam int xlen = 32;

    // access width and kind as seen by the data memory
    typedef enum logic [2:0]
    {
        mode_word,
        mode_half,
        mode_byte,
        mode_uhalf,
        mode_ubyte
    } mem_mode_t;

    // writeback source select
    typedef enum logic [1:0]
    {
        res_alu,
        res_mem,
        res_pc4
    } result_src_t;

    // load/store funct3 encodings
    localparam logic [2:0] f3_byte  = 3'b000;
    localparam logic [2:0] f3_half  = 3'b001;
    localparam logic [2:0] f3_word  = 3'b010;
    localparam logic [2:0] f3_ubyte = 3'b100;
    localparam logic [2:0] f3_uhalf = 3'b101;

endpackage

// ==== mem_wb_stim.txt ====
// test funct3 mem_read mem_write result_src rd reg_write alu_result store_data pc exp_result exp_trap
// all fields hex, lines of one test run back to back
1 2 0 1 0 00 0 00000100 deadbeef 00000000 00000100 0
1 2 1 0 1 05 1 00000100 00000000 00000004 deadbeef 0
1 2 0 1 0 00 0 00000104 12345678 00000008 00000104 0
1 2 1 0 1 06 1 00001104 00000000 0000000c 12345678 0
2 1 0 1 0 00 0 00000200 abcd8001 00000010 00000200 0
2 0 0 1 0 00 0 00000202 123456f5 00000014 00000202 0
2 0 0 1 0 00 0 00000203 0000007a 00000018 00000203 0
2 1 1 0 1 07 1 00000200 00000000 0000001c ffff8001 0
2 5 1 0 1 08 1 00000200 00000000 00000020 00008001 0
2 0 1 0 1 09 1 00000202 00000000 00000024 fffffff5 0
2 4 1 0 1 0a 1 00000202 00000000 00000028 000000f5 0
2 0 1 0 1 0b 1 00000203 00000000 0000002c 0000007a 0
2 2 1 0 1 0c 1 00000200 00000000 00000030 8001f57a 0
2 1 1 0 1 0d 1 00000202 00000000 00000034 fffff57a 0
3 2 0 1 0 00 0 00000102 11111111 00000038 00000102 1
3 1 0 1 0 00 0 00000101 00002222 0000003c 00000101 1
3 2 1 0 1 0e 1 00000100 00000000 00000040 deadbeef 0
3 2 1 0 1 0f 1 00000101 00000000 00000044 00000000 1
3 5 1 0 1 10 1 00000103 00000000 00000048 00000000 1
3 3 1 0 1 11 1 00000100 00000000 0000004c 00000000 1
3 0 1 0 1 12 1 00000101 00000000 00000050 ffffffad 0
4 0 0 0 0 13 1 cafef00d 00000000 00000054 cafef00d 0
4 0 0 0 2 14 1 12345678 00000000 00000058 0000005c 0
4 7 0 0 2 15 1 00000000 00000000 fffffffc 00000000 0
4 3 0 0 0 16 0 00000abc 00000000 00000060 00000abc 0
5 2 0 1 0 00 0 00000300 a5a55a5a 00000100 00000300 0
5 2 1 0 1 01 1 00000300 00000000 00000104 a5a55a5a 0
5 0 0 1 0 00 0 00000301 00000000 00000108 00000301 0
5 2 1 0 1 02 1 00000300 00000000 0000010c a5005a5a 0
5 1 0 1 0 00 0 00000302 0000c3c3 00000110 00000302 0
5 5 1 0 1 03 1 00000302 00000000 00000114 0000c3c3 0
5 2 1 0 1 04 1 00000300 00000000 00000118 a500c3c3 0
6 2 1 0 1 1f 1 00000800 00000000 0000011c 00000000 0
6 1 1 0 1 1e 1 00000ffe 00000000 00000120 00000000 0
6 0 1 0 1 1d 1 00000fff 00000000 00000124 00000000 0
6 2 1 0 1 1c 1 00000ffc 00000000 00000128 00000000 0

// ==== mem_wb_top.sv ====
module mem_wb_top #(
    parameter int addr_width = 12
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [2:0]                  funct3,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  mem_wb_pkg::result_src_t     result_src,
    input  logic [4:0]                  rd,
    input  logic                        reg_write,
    input  logic [mem_wb_pkg::xlen-1:0] alu_result,
    input  logic [mem_wb_pkg::xlen-1:0] store_data,
    input  logic [mem_wb_pkg::xlen-1:0] pc,
    output logic                        wb_valid,
    output logic [4:0]                  wb_rd,
    output logic [mem_wb_pkg::xlen-1:0] wb_result,
    output logic                        wb_reg_write,
    output logic                        wb_trap
);
    import mem_wb_pkg::*;

    logic            misaligned;
    logic [xlen-1:0] load_data;

    mem_bus_if #(.addr_width(addr_width)) mem_bus ();

    lsu_decode #(.addr_width(addr_width)) u_lsu_decode (
        .funct3     (funct3),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .in_valid   (in_valid),
        .alu_result (alu_result),
        .store_data (store_data),
        .misaligned (misaligned),
        .load_data  (load_data),
        .bus        (mem_bus.requester)
    );

    data_memory #(.addr_width(addr_width)) u_data_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.memory)
    );

    writeback_stage u_writeback_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .result_src   (result_src),
        .rd           (rd),
        .reg_write    (reg_write),
        .trap         (misaligned), // alignment fault becomes the trap flag
        .alu_result   (alu_result),
        .load_data    (load_data),
        .pc           (pc),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_result    (wb_result),
        .wb_reg_write (wb_reg_write),
        .wb_trap      (wb_trap)
    );

endmodule

// ==== tb_mem_wb.sv ====
module tb_mem_wb;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_wb_pkg::*;

    localparam int fields    = 12;
    localparam int max_lines = 64;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic [2:0]        funct3;
    logic              mem_read;
    logic              mem_write;
    result_src_t       result_src;
    logic [4:0]        rd;
    logic              reg_write;
    logic [xlen-1:0]   alu_result;
    logic [xlen-1:0]   store_data;
    logic [xlen-1:0]   pc;
    logic              wb_valid;
    logic [4:0]        wb_rd;
    logic [xlen-1:0]   wb_result;
    logic              wb_reg_write;
    logic              wb_trap;

    logic [31:0] stim [max_lines*fields];
    int          n_lines;
    int          errors;
    int          current_test;
    int          test_first;
    int          test_err_base;
    int          tests_done;
    int          pending;
    int          cycle_count;
    int          cycle_limit = 1000;
    int          idle;

    mem_wb_top #(.addr_width(12)) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .funct3       (funct3),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .result_src   (result_src),
        .rd           (rd),
        .reg_write    (reg_write),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .pc           (pc),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_result    (wb_result),
        .wb_reg_write (wb_reg_write),
        .wb_trap      (wb_trap)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] field(input int line, input int k);
        return stim[line*fields + k];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s = %h, expected %h (test %0d)", name, got, exp, current_test);
            errors++;
        end
    endtask

    // compare the writeback outputs of the line issued one cycle earlier
    task automatic check_pending();
        logic trap_exp;
        logic last;
        if (pending < 0)
        begin
            check_value("wb_valid", wb_valid, 32'h0);
        end
        else
        begin
            current_test = field(pending, 0);
            if (pending == 0 || field(pending - 1, 0) != field(pending, 0))
            begin
                test_first    = pending;
                test_err_base = errors;
            end
            trap_exp = 1'(field(pending, 11));
            check_value("wb_valid", wb_valid, 32'h1);
            check_value("wb_rd", wb_rd, field(pending, 5));
            check_value("wb_trap", wb_trap, trap_exp);
            check_value("wb_reg_write", wb_reg_write, 1'(field(pending, 6)) & ~trap_exp);
            if (!trap_exp)
                check_value("wb_result", wb_result, field(pending, 10));
            last = (pending + 1 == n_lines) || (field(pending + 1, 0) != field(pending, 0));
            if (last)
            begin
                tests_done++;
                $display("test %0d done: %0d lines, %0d errors", current_test,
                         pending - test_first + 1, errors - test_err_base);
            end
        end
    endtask

    task automatic drive_line(input int i);
        in_valid   = 1'b1;
        funct3     = 3'(field(i, 1));
        mem_read   = 1'(field(i, 2));
        mem_write  = 1'(field(i, 3));
        result_src = result_src_t'(2'(field(i, 4)));
        rd         = 5'(field(i, 5));
        reg_write  = 1'(field(i, 6));
        alu_result = field(i, 7);
        store_data = field(i, 8);
        pc         = field(i, 9);
    endtask

    task automatic drive_idle();
        in_valid  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
    endtask

    initial
    begin
        void'($urandom(44544));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        funct3     = f3_word;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        result_src = res_alu;
        rd         = 5'd0;
        reg_write  = 1'b0;
        alu_result = '0;
        store_data = '0;
        pc         = '0;
        errors     = 0;
        tests_done = 0;
        pending    = -1;
        cycle_count = 0;

        $readmemh("mem_wb_stim.txt", stim);
        n_lines = 0;
        while (n_lines < max_lines && !$isunknown(field(n_lines, 0)) && field(n_lines, 0) != 0)
            n_lines++;
        cycle_limit = 4 * (n_lines + 10); // idle gaps fit well inside this margin

        if (n_lines == 0)
        begin
            $display("no stimulus lines found in mem_wb_stim.txt");
            $display("sim failed");
            $finish;
        end
        else
        begin
            repeat (10) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;

            for (int i = 0; i < n_lines; i++)
            begin
                if (i > 0 && field(i, 0) != field(i - 1, 0))
                begin
                    idle = $urandom_range(0, 3); // gaps only between tests
                    repeat (idle)
                    begin
                        @(negedge clk);
                        check_pending();
                        drive_idle();
                        pending = -1;
                    end
                end
                @(negedge clk);
                check_pending();
                drive_line(i);
                pending = i;
            end
            @(negedge clk);
            check_pending();
            drive_idle();
            pending = -1;

            $display("%0d tests, %0d lines, %0d errors, %0d assertion failures",
                     tests_done, n_lines, errors, dut.u_checker.assert_fails);
            if (errors == 0 && dut.u_checker.assert_fails == 0)
                $display("sim passed");
            else
                $display("sim failed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
mem_wb_pkg.sv
mem_bus_if.sv
lsu_decode.sv
data_memory.sv
writeback_stage.sv
mem_wb_top.sv
mem_wb_checker.sv
tb_mem_wb.sv

// ==== writeback_stage.sv ====
module writeback_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  mem_wb_pkg::result_src_t       result_src,
    input  logic [4:0]                    rd,
    input  logic                          reg_write,
    input  logic                          trap,
    input  logic [mem_wb_pkg::xlen-1:0]   alu_result,
    input  logic [mem_wb_pkg::xlen-1:0]   load_data,
    input  logic [mem_wb_pkg::xlen-1:0]   pc,
    output logic                          wb_valid,
    output logic [4:0]                    wb_rd,
    output logic [mem_wb_pkg::xlen-1:0]   wb_result,
    output logic                          wb_reg_write,
    output logic                          wb_trap
);
    import mem_wb_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] result_sel;

    assign pc_plus4 = pc + xlen'(4); // link value for jumps

    always_comb
    begin
        case (result_src)
            res_mem: result_sel = load_data;
            res_pc4: result_sel = pc_plus4;
            default: result_sel = alu_result;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_trap      <= 1'b0;
        end
        else
        begin
            wb_valid     <= in_valid;
            wb_reg_write <= in_valid & reg_write & ~trap; // no write on a trapped access
            wb_trap      <= in_valid & trap;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_rd     <= rd;
        wb_result <= result_sel;
    end

endmodule
